//--- include/lsu_config.svh
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

// first byte of the sram window
`define LSU_MEM_BASE 32'h8000_0000

// depth in 32-bit words
`define LSU_MEM_WORDS 256

`define LSU_ADDR_W 32

`endif

//--- hw/lsu_pkg.sv
`default_nettype none

`include "lsu_config.svh"

package lsu_pkg;

    typedef enum logic [3:0] {
        OP_NONE,
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_SB,
        OP_SH,
        OP_SW
    } lsu_op_e;

    typedef enum logic [1:0] {CTRL_IDLE, CTRL_LOAD, CTRL_STORE, CTRL_OUT} ctrl_state_e;
    typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_e;
    typedef enum logic [1:0] {WR_IDLE, WR_REQ, WR_RESP} wr_state_e;

    typedef struct packed {
        lsu_op_e                op;
        logic [`LSU_ADDR_W-1:0] addr;
        logic [31:0]            wdata;
        logic [4:0]             rd;
        logic                   gpr_we;
    } lsu_req_t;

    typedef struct packed {
        logic [31:0] result;
        logic [4:0]  rd;
        logic        gpr_we;
        logic        fault;
    } lsu_wb_t;

    typedef struct packed {
        lsu_op_e                op;
        logic [`LSU_ADDR_W-1:0] addr;
        logic [31:0]            wdata;
    } mem_cmd_t;

    typedef struct packed {
        logic [31:0] data;
        logic        fault;
    } mem_rsp_t;

    typedef struct packed {
        logic [`LSU_ADDR_W-1:0] addr;
        logic [2:0]             size;
    } axi_ar_t;

    typedef axi_ar_t axi_aw_t; // same fields as ar

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axi_w_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
    } axi_r_t;

    typedef struct packed {
        logic [1:0] resp;
    } axi_b_t;

    function automatic logic is_load(input lsu_op_e op);
        return op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
    endfunction

    function automatic logic is_store(input lsu_op_e op);
        return op inside {OP_SB, OP_SH, OP_SW};
    endfunction

    // log2 of the access width in bytes
    function automatic logic [2:0] axi_size(input lsu_op_e op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return 3'd0;
            OP_LH, OP_LHU, OP_SH: return 3'd1;
            default:              return 3'd2;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- hw/lsu_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_ctrl (
    input  wire                clk,
    input  wire                rst,
    input  wire                in_valid,
    output logic               in_ready,
    input  wire lsu_pkg::lsu_req_t in_req,
    output logic               out_valid,
    input  wire                out_ready,
    output lsu_pkg::lsu_wb_t   out_wb,
    output logic               rd_start,
    output lsu_pkg::mem_cmd_t  rd_cmd,
    input  wire                rd_done,
    input  wire lsu_pkg::mem_rsp_t rd_rsp,
    output logic               wr_start,
    output lsu_pkg::mem_cmd_t  wr_cmd,
    input  wire                wr_done,
    input  wire lsu_pkg::mem_rsp_t wr_rsp
);
    lsu_pkg::ctrl_state_e state;
    lsu_pkg::lsu_req_t    req_q;
    lsu_pkg::mem_cmd_t    cmd_q;
    logic                 accept;
    logic                 in_load;
    logic                 in_store;
    logic                 in_misal;

    assign in_ready  = (state == lsu_pkg::CTRL_IDLE);
    assign out_valid = (state == lsu_pkg::CTRL_OUT);
    assign accept    = in_valid & in_ready;

    assign in_load  = lsu_pkg::is_load(in_req.op);
    assign in_store = lsu_pkg::is_store(in_req.op);

    always_comb begin
        case (in_req.op)
            lsu_pkg::OP_LH, lsu_pkg::OP_LHU, lsu_pkg::OP_SH: in_misal = in_req.addr[0];
            lsu_pkg::OP_LW, lsu_pkg::OP_SW:                  in_misal = |in_req.addr[1:0];
            default:                                         in_misal = 1'b0;
        endcase
    end

    // both engines see the same saved request
    assign cmd_q.op    = req_q.op;
    assign cmd_q.addr  = req_q.addr;
    assign cmd_q.wdata = req_q.wdata;
    assign rd_cmd      = cmd_q;
    assign wr_cmd      = cmd_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= lsu_pkg::CTRL_IDLE;
            rd_start <= 1'b0;
            wr_start <= 1'b0;
        end else begin
            rd_start <= 1'b0;
            wr_start <= 1'b0;
            case (state)
                lsu_pkg::CTRL_IDLE: begin
                    if (accept) begin
                        if (in_misal || !(in_load || in_store)) begin
                            state <= lsu_pkg::CTRL_OUT; // no bus traffic
                        end else if (in_load) begin
                            state    <= lsu_pkg::CTRL_LOAD;
                            rd_start <= 1'b1;
                        end else begin
                            state    <= lsu_pkg::CTRL_STORE;
                            wr_start <= 1'b1;
                        end
                    end
                end
                lsu_pkg::CTRL_LOAD: begin
                    if (rd_done) state <= lsu_pkg::CTRL_OUT;
                end
                lsu_pkg::CTRL_STORE: begin
                    if (wr_done) state <= lsu_pkg::CTRL_OUT;
                end
                lsu_pkg::CTRL_OUT: begin
                    if (out_ready) state <= lsu_pkg::CTRL_IDLE;
                end
                default: state <= lsu_pkg::CTRL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q         <= in_req;
            out_wb.rd     <= in_req.rd;
            out_wb.result <= in_misal ? '0 : in_req.addr; // pass-through result
            out_wb.gpr_we <= in_req.gpr_we & ~in_misal;
            out_wb.fault  <= in_misal;
        end
        if (rd_done && state == lsu_pkg::CTRL_LOAD) begin
            out_wb.result <= rd_rsp.fault ? '0 : rd_rsp.data;
            out_wb.gpr_we <= req_q.gpr_we & ~rd_rsp.fault;
            out_wb.fault  <= rd_rsp.fault;
        end
        if (wr_done && state == lsu_pkg::CTRL_STORE) begin
            out_wb.result <= '0;
            out_wb.gpr_we <= 1'b0; // stores never write a gpr
            out_wb.fault  <= wr_rsp.fault;
        end
    end

endmodule

`default_nettype wire

//--- hw/lsu_rd_engine.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_rd_engine (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    start,
    input  wire lsu_pkg::mem_cmd_t cmd,
    output logic                   done,
    output lsu_pkg::mem_rsp_t      rsp,
    output logic                   arvalid,
    input  wire                    arready,
    output lsu_pkg::axi_ar_t       ar,
    input  wire                    rvalid,
    output logic                   rready,
    input  wire lsu_pkg::axi_r_t   r
);
    lsu_pkg::rd_state_e state;
    lsu_pkg::lsu_op_e   op_q;
    logic [1:0]         off_q;
    logic [31:0]        shifted;
    logic [31:0]        ext;

    assign shifted = r.data >> {off_q, 3'b000};

    always_comb begin
        case (op_q)
            lsu_pkg::OP_LB:  ext = {{24{shifted[7]}}, shifted[7:0]};
            lsu_pkg::OP_LBU: ext = {24'b0, shifted[7:0]};
            lsu_pkg::OP_LH:  ext = {{16{shifted[15]}}, shifted[15:0]};
            lsu_pkg::OP_LHU: ext = {16'b0, shifted[15:0]};
            default:         ext = shifted;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= lsu_pkg::RD_IDLE;
            arvalid <= 1'b0;
            rready  <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                lsu_pkg::RD_IDLE: begin
                    if (start) begin
                        arvalid <= 1'b1;
                        state   <= lsu_pkg::RD_ADDR;
                    end
                end
                lsu_pkg::RD_ADDR: begin
                    if (arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state   <= lsu_pkg::RD_DATA;
                    end
                end
                lsu_pkg::RD_DATA: begin
                    if (rvalid) begin
                        rready <= 1'b0;
                        done   <= 1'b1;
                        state  <= lsu_pkg::RD_IDLE;
                    end
                end
                default: state <= lsu_pkg::RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && state == lsu_pkg::RD_IDLE) begin
            ar.addr <= cmd.addr;
            ar.size <= lsu_pkg::axi_size(cmd.op);
            op_q    <= cmd.op;
            off_q   <= cmd.addr[1:0];
        end
        if (rvalid && rready) begin
            rsp.data  <= ext;
            rsp.fault <= (r.resp != 2'b00); // slverr or decerr
        end
    end

endmodule

`default_nettype wire

//--- hw/lsu_wr_engine.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_wr_engine (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    start,
    input  wire lsu_pkg::mem_cmd_t cmd,
    output logic                   done,
    output lsu_pkg::mem_rsp_t      rsp,
    output logic                   awvalid,
    input  wire                    awready,
    output lsu_pkg::axi_aw_t       aw,
    output logic                   wvalid,
    input  wire                    wready,
    output lsu_pkg::axi_w_t        w,
    input  wire                    bvalid,
    output logic                   bready,
    input  wire lsu_pkg::axi_b_t   b
);
    lsu_pkg::wr_state_e state;
    logic [3:0]         strb_base;
    logic               aw_ok;
    logic               w_ok;

    always_comb begin
        case (cmd.op)
            lsu_pkg::OP_SB: strb_base = 4'b0001;
            lsu_pkg::OP_SH: strb_base = 4'b0011;
            lsu_pkg::OP_SW: strb_base = 4'b1111;
            default:        strb_base = 4'b0000;
        endcase
    end

    // channel finished already or finishing now
    assign aw_ok = ~awvalid | awready;
    assign w_ok  = ~wvalid | wready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= lsu_pkg::WR_IDLE;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bready  <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                lsu_pkg::WR_IDLE: begin
                    if (start) begin
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                        state   <= lsu_pkg::WR_REQ;
                    end
                end
                lsu_pkg::WR_REQ: begin
                    if (awready) awvalid <= 1'b0;
                    if (wready) wvalid <= 1'b0;
                    if (aw_ok && w_ok) begin
                        bready <= 1'b1;
                        state  <= lsu_pkg::WR_RESP;
                    end
                end
                lsu_pkg::WR_RESP: begin
                    if (bvalid) begin
                        bready <= 1'b0;
                        done   <= 1'b1;
                        state  <= lsu_pkg::WR_IDLE;
                    end
                end
                default: state <= lsu_pkg::WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start && state == lsu_pkg::WR_IDLE) begin
            aw.addr <= cmd.addr;
            aw.size <= lsu_pkg::axi_size(cmd.op);
            w.data  <= cmd.wdata << {cmd.addr[1:0], 3'b000};
            w.strb  <= strb_base << cmd.addr[1:0];
        end
        if (bvalid && bready) begin
            rsp.data  <= '0;
            rsp.fault <= (b.resp != 2'b00);
        end
    end

endmodule

`default_nettype wire

//--- hw/axi_sram.sv
`timescale 1ns/1ns
`default_nettype none

`include "lsu_config.svh"

module axi_sram (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  arvalid,
    output logic                 arready,
    input  wire lsu_pkg::axi_ar_t ar,
    output logic                 rvalid,
    input  wire                  rready,
    output lsu_pkg::axi_r_t      r,
    input  wire                  awvalid,
    output logic                 awready,
    input  wire lsu_pkg::axi_aw_t aw,
    input  wire                  wvalid,
    output logic                 wready,
    input  wire lsu_pkg::axi_w_t w,
    output logic                 bvalid,
    input  wire                  bready,
    output lsu_pkg::axi_b_t      b
);
    localparam int IDX_W = $clog2(`LSU_MEM_WORDS);
    localparam logic [`LSU_ADDR_W-1:0] MEM_BYTES = `LSU_MEM_WORDS * 4;

    logic [31:0]            mem [`LSU_MEM_WORDS];
    lsu_pkg::axi_aw_t       aw_q;
    lsu_pkg::axi_w_t        w_q;
    logic                   aw_have;
    logic                   w_have;
    lsu_pkg::axi_aw_t       aw_cur;
    lsu_pkg::axi_w_t        w_cur;
    logic                   aw_got;
    logic                   w_got;
    logic                   rd_fire;
    logic                   wr_fire;
    logic                   rd_hit;
    logic                   wr_hit;
    logic [`LSU_ADDR_W-1:0] rd_off;
    logic [`LSU_ADDR_W-1:0] wr_off;

    function automatic logic in_window(input logic [`LSU_ADDR_W-1:0] a);
        return (a >= `LSU_MEM_BASE) && ((a - `LSU_MEM_BASE) < MEM_BYTES);
    endfunction

    // address ready drops while a response waits
    assign arready = ~rvalid;
    assign awready = ~aw_have & ~bvalid;
    assign wready  = ~w_have & ~bvalid;

    assign rd_fire = arvalid & arready;
    assign aw_got  = aw_have | (awvalid & awready);
    assign w_got   = w_have | (wvalid & wready);
    assign wr_fire = aw_got & w_got & ~bvalid;
    assign aw_cur  = aw_have ? aw_q : aw;
    assign w_cur   = w_have ? w_q : w;

    assign rd_hit = in_window(ar.addr);
    assign wr_hit = in_window(aw_cur.addr);
    assign rd_off = ar.addr - `LSU_MEM_BASE;
    assign wr_off = aw_cur.addr - `LSU_MEM_BASE;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rvalid  <= 1'b0;
            bvalid  <= 1'b0;
            aw_have <= 1'b0;
            w_have  <= 1'b0;
        end else begin
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            if (wr_fire) begin
                bvalid  <= 1'b1;
                aw_have <= 1'b0;
                w_have  <= 1'b0;
            end else begin
                if (awvalid && awready) aw_have <= 1'b1; // w still missing
                if (wvalid && wready) w_have <= 1'b1;
                if (bvalid && bready) bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready) aw_q <= aw;
        if (wvalid && wready) w_q <= w;
        if (rd_fire) begin
            r.data <= rd_hit ? mem[rd_off[IDX_W+1:2]] : '0;
            r.resp <= rd_hit ? 2'b00 : 2'b10;
        end
        if (wr_fire) begin
            b.resp <= wr_hit ? 2'b00 : 2'b10;
            if (wr_hit) begin
                for (int i = 0; i < 4; i++) begin
                    if (w_cur.strb[i]) mem[wr_off[IDX_W+1:2]][8*i +: 8] <= w_cur.data[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/lsu_top.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_top (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    in_valid,
    output logic                   in_ready,
    input  wire lsu_pkg::lsu_req_t in_req,
    output logic                   out_valid,
    input  wire                    out_ready,
    output lsu_pkg::lsu_wb_t       out_wb
);
    logic              rd_start;
    lsu_pkg::mem_cmd_t rd_cmd;
    logic              rd_done;
    lsu_pkg::mem_rsp_t rd_rsp;
    logic              wr_start;
    lsu_pkg::mem_cmd_t wr_cmd;
    logic              wr_done;
    lsu_pkg::mem_rsp_t wr_rsp;

    logic              arvalid;
    logic              arready;
    lsu_pkg::axi_ar_t  ar;
    logic              rvalid;
    logic              rready;
    lsu_pkg::axi_r_t   r;
    logic              awvalid;
    logic              awready;
    lsu_pkg::axi_aw_t  aw;
    logic              wvalid;
    logic              wready;
    lsu_pkg::axi_w_t   w;
    logic              bvalid;
    logic              bready;
    lsu_pkg::axi_b_t   b;

    lsu_ctrl i_lsu_ctrl (
        .clk, .rst,
        .in_valid, .in_ready, .in_req,
        .out_valid, .out_ready, .out_wb,
        .rd_start, .rd_cmd, .rd_done, .rd_rsp,
        .wr_start, .wr_cmd, .wr_done, .wr_rsp
    );

    lsu_rd_engine i_lsu_rd_engine (
        .clk, .rst,
        .start (rd_start),
        .cmd   (rd_cmd),
        .done  (rd_done),
        .rsp   (rd_rsp),
        .arvalid, .arready, .ar,
        .rvalid, .rready, .r
    );

    lsu_wr_engine i_lsu_wr_engine (
        .clk, .rst,
        .start (wr_start),
        .cmd   (wr_cmd),
        .done  (wr_done),
        .rsp   (wr_rsp),
        .awvalid, .awready, .aw,
        .wvalid, .wready, .w,
        .bvalid, .bready, .b
    );

    axi_sram i_axi_sram (
        .clk, .rst,
        .arvalid, .arready, .ar,
        .rvalid, .rready, .r,
        .awvalid, .awready, .aw,
        .wvalid, .wready, .w,
        .bvalid, .bready, .b
    );

endmodule

`default_nettype wire

//--- tests/lsu_checker.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_checker (
    input wire                   clk,
    input wire                   rst,
    input wire                   in_ready,
    input wire                   out_valid,
    input wire                   out_ready,
    input wire lsu_pkg::lsu_wb_t out_wb,
    input wire                   arvalid,
    input wire                   arready,
    input wire                   awvalid,
    input wire                   awready,
    input wire                   wvalid,
    input wire                   wready
);
    int fail_cnt = 0;

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid)
    else begin
        fail_cnt++;
        $error("arvalid dropped before arready");
    end

    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid)
    else begin
        fail_cnt++;
        $error("awvalid dropped before awready");
    end

    a_w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid)
    else begin
        fail_cnt++;
        $error("wvalid dropped before wready");
    end

    // record frozen while writeback stalls
    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_wb))
    else begin
        fail_cnt++;
        $error("writeback record changed under back-pressure");
    end

    a_ready_after_reset: assert property (@(posedge clk) $fell(rst) |-> in_ready)
    else begin
        fail_cnt++;
        $error("in_ready low right after reset");
    end

endmodule

bind lsu_top lsu_checker i_lsu_checker (
    .clk       (clk),
    .rst       (rst),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_wb    (out_wb),
    .arvalid   (arvalid),
    .arready   (arready),
    .awvalid   (awvalid),
    .awready   (awready),
    .wvalid    (wvalid),
    .wready    (wready)
);

`default_nettype wire

//--- tests/lsu_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "lsu_config.svh"

module lsu_tb;
    localparam int MEM_BYTES   = `LSU_MEM_WORDS * 4;
    localparam int CYCLE_LIMIT = 3000; // ~150 requests at ~20 cycles

    logic              clk;
    logic              rst;
    logic              in_valid;
    logic              in_ready;
    lsu_pkg::lsu_req_t in_req;
    logic              out_valid;
    logic              out_ready;
    lsu_pkg::lsu_wb_t  out_wb;

    logic [7:0] shadow [MEM_BYTES];
    integer     seed;
    int         errors;
    int         cycles;

    lsu_top i_lsu_top (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_wb    (out_wb)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TB FAILED");
        $finish;
    end

    function automatic logic in_window(input logic [31:0] a);
        return (a >= `LSU_MEM_BASE) && ((a - `LSU_MEM_BASE) < 32'(MEM_BYTES));
    endfunction

    function automatic int rand_word();
        return {$random(seed)} % `LSU_MEM_WORDS;
    endfunction

    // little-endian pick from shadow bytes, then extension by opcode
    function automatic logic [31:0] load_value(input lsu_pkg::lsu_op_e op, input int off);
        logic [7:0]  b;
        logic [15:0] h;
        b = shadow[off];
        case (op)
            lsu_pkg::OP_LB:  return {{24{b[7]}}, b};
            lsu_pkg::OP_LBU: return {24'h0, b};
            lsu_pkg::OP_LH: begin
                h = {shadow[off + 1], b};
                return {{16{h[15]}}, h};
            end
            lsu_pkg::OP_LHU: begin
                h = {shadow[off + 1], b};
                return {16'h0, h};
            end
            default: return {shadow[off + 3], shadow[off + 2], shadow[off + 1], b};
        endcase
    endfunction

    task automatic check_wb(input lsu_pkg::lsu_wb_t got, input lsu_pkg::lsu_wb_t exp,
                            input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got result %h rd %0d we %b fault %b, exp %h %0d %b %b",
                     $time, what, got.result, got.rd, got.gpr_we, got.fault,
                     exp.result, exp.rd, exp.gpr_we, exp.fault);
            errors++;
        end
    endtask

    // lat is the number of falling edges between acceptance and out_valid
    task automatic do_req(input lsu_pkg::lsu_req_t req, input int hold,
                          output lsu_pkg::lsu_wb_t wb, output int lat);
        lsu_pkg::lsu_req_t extra;
        int                waited;
        int                i;
        wb       = '0;
        lat      = -1;
        in_req   = req;
        in_valid = 1'b1;
        waited   = 0;
        while (!in_ready && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (!in_ready) begin
            $display("request at %0t was never accepted", $time);
            errors++;
            in_valid = 1'b0;
            return;
        end
        @(negedge clk);
        in_valid = 1'b0;
        waited   = 0;
        while (!out_valid && waited < 40) begin
            @(negedge clk);
            waited++;
        end
        if (!out_valid) begin
            $display("no writeback record for the request accepted before %0t", $time);
            errors++;
            return;
        end
        lat         = waited;
        wb          = out_wb;
        extra       = req;
        extra.op    = lsu_pkg::OP_NONE;
        extra.addr  = ~req.addr;
        extra.rd    = req.rd ^ 5'h1f;
        for (i = 0; i < hold; i++) begin
            if (i == 0) begin
                in_req   = extra; // competing request while stalled
                in_valid = 1'b1;
            end
            @(negedge clk);
            if (!out_valid || out_wb !== wb || in_ready) begin
                $display("Mismatch at %0t: record or in_ready not held under back-pressure",
                         $time);
                errors++;
            end
        end
        in_valid  = 1'b0;
        out_ready = 1'b1;
        @(negedge clk);
        out_ready = 1'b0;
    endtask

    task automatic mem_op(input lsu_pkg::lsu_op_e op, input logic [31:0] addr,
                          input logic [31:0] data);
        lsu_pkg::lsu_req_t req;
        lsu_pkg::lsu_wb_t  wb;
        lsu_pkg::lsu_wb_t  exp;
        int                lat;
        int                size;
        int                off;
        int                i;
        logic              misal;
        logic              is_st;
        case (op)
            lsu_pkg::OP_LB, lsu_pkg::OP_LBU, lsu_pkg::OP_SB: size = 1;
            lsu_pkg::OP_LH, lsu_pkg::OP_LHU, lsu_pkg::OP_SH: size = 2;
            default:                                         size = 4;
        endcase
        is_st = (op == lsu_pkg::OP_SB) || (op == lsu_pkg::OP_SH) || (op == lsu_pkg::OP_SW);
        misal = (size == 2 && addr[0]) || (size == 4 && addr[1:0] != 2'b00);
        off   = int'(addr - `LSU_MEM_BASE);
        req.op     = op;
        req.addr   = addr;
        req.wdata  = data;
        req.rd     = 5'($random(seed));
        req.gpr_we = 1'($random(seed));
        exp.result = '0;
        exp.rd     = req.rd;
        exp.gpr_we = 1'b0;
        exp.fault  = 1'b1;
        if (!misal && in_window(addr)) begin
            exp.fault = 1'b0;
            if (!is_st) begin
                exp.result = load_value(op, off);
                exp.gpr_we = req.gpr_we;
            end
        end
        do_req(req, 0, wb, lat);
        if (lat < 0) return;
        check_wb(wb, exp, "memory access");
        if (misal && lat != 0) begin
            $display("Mismatch at %0t: misaligned request took %0d extra cycles", $time, lat);
            errors++;
        end
        if (is_st && !exp.fault) begin
            for (i = 0; i < size; i++) shadow[off + i] = data[8*i +: 8];
        end
    endtask

    task automatic word_store_load();
        logic [31:0] addr;
        int          n;
        for (n = 0; n < 8; n++) begin
            addr = `LSU_MEM_BASE + 4 * rand_word();
            mem_op(lsu_pkg::OP_SW, addr, $random(seed));
            mem_op(lsu_pkg::OP_LW, addr, 32'h0);
        end
    endtask

    task automatic sub_word_stores();
        logic [31:0] addr;
        int          n;
        int          k;
        for (n = 0; n < 2; n++) begin
            addr = `LSU_MEM_BASE + 4 * rand_word();
            mem_op(lsu_pkg::OP_SW, addr, $random(seed));
            for (k = 0; k < 4; k++) mem_op(lsu_pkg::OP_SB, addr + k, $random(seed));
            mem_op(lsu_pkg::OP_LW, addr, 32'h0);
            mem_op(lsu_pkg::OP_SH, addr, $random(seed));
            mem_op(lsu_pkg::OP_SH, addr + 2, $random(seed));
            mem_op(lsu_pkg::OP_LW, addr, 32'h0);
        end
    endtask

    task automatic sub_word_loads();
        logic [31:0] addr;
        int          n;
        int          k;
        for (n = 0; n < 2; n++) begin
            addr = `LSU_MEM_BASE + 4 * rand_word();
            // fixed word mixes positive and negative bytes and halves
            mem_op(lsu_pkg::OP_SW, addr, (n == 0) ? 32'h80f7_7f81 : $random(seed));
            for (k = 0; k < 4; k++) begin
                mem_op(lsu_pkg::OP_LB, addr + k, 32'h0);
                mem_op(lsu_pkg::OP_LBU, addr + k, 32'h0);
            end
            for (k = 0; k < 4; k += 2) begin
                mem_op(lsu_pkg::OP_LH, addr + k, 32'h0);
                mem_op(lsu_pkg::OP_LHU, addr + k, 32'h0);
            end
        end
    endtask

    task automatic out_of_range_access();
        logic [31:0] first;
        logic [31:0] last;
        first = `LSU_MEM_BASE;
        last  = `LSU_MEM_BASE + MEM_BYTES - 4;
        mem_op(lsu_pkg::OP_SW, first, $random(seed));
        mem_op(lsu_pkg::OP_SW, last, $random(seed));
        mem_op(lsu_pkg::OP_SW, last + 4, $random(seed)); // one past the window
        mem_op(lsu_pkg::OP_SB, first - 1, $random(seed));
        mem_op(lsu_pkg::OP_SH, 32'h0000_0100, $random(seed));
        mem_op(lsu_pkg::OP_LW, last + 4, 32'h0);
        mem_op(lsu_pkg::OP_LB, first - 1, 32'h0);
        mem_op(lsu_pkg::OP_LHU, 32'h0000_0100, 32'h0);
        mem_op(lsu_pkg::OP_LW, last, 32'h0);
        mem_op(lsu_pkg::OP_LW, first, 32'h0);
    endtask

    task automatic misaligned_access();
        logic [31:0] addr;
        int          k;
        addr = `LSU_MEM_BASE + 4 * rand_word();
        mem_op(lsu_pkg::OP_SW, addr, $random(seed));
        mem_op(lsu_pkg::OP_LH, addr + 1, 32'h0);
        mem_op(lsu_pkg::OP_LHU, addr + 3, 32'h0);
        mem_op(lsu_pkg::OP_SH, addr + 1, $random(seed));
        mem_op(lsu_pkg::OP_SH, addr + 3, $random(seed));
        for (k = 1; k < 4; k++) begin
            mem_op(lsu_pkg::OP_LW, addr + k, 32'h0);
            mem_op(lsu_pkg::OP_SW, addr + k, $random(seed));
        end
        mem_op(lsu_pkg::OP_LW, addr, 32'h0);
    endtask

    task automatic pass_through_stall();
        lsu_pkg::lsu_req_t req;
        lsu_pkg::lsu_wb_t  wb;
        lsu_pkg::lsu_wb_t  exp;
        int                lat;
        int                n;
        for (n = 0; n < 4; n++) begin
            req.op     = lsu_pkg::OP_NONE;
            req.addr   = $random(seed);
            req.wdata  = $random(seed);
            req.rd     = 5'($random(seed));
            req.gpr_we = (n != 1);
            exp.result = req.addr;
            exp.rd     = req.rd;
            exp.gpr_we = req.gpr_we;
            exp.fault  = 1'b0;
            do_req(req, (n == 2) ? 6 : 0, wb, lat); // third one stalls writeback
            if (lat >= 0) begin
                check_wb(wb, exp, "pass-through");
                if (lat != 0) begin
                    $display("Mismatch at %0t: pass-through took %0d extra cycles", $time, lat);
                    errors++;
                end
            end
        end
    endtask

    initial begin
        int i;
        int total;
        seed      = 32'ha9eb_d9d7;
        errors    = 0;
        rst       = 1'b1;
        in_valid  = 1'b0;
        in_req    = '0;
        out_ready = 1'b0;
        for (i = 0; i < MEM_BYTES; i++) shadow[i] = 8'h00;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        if (!in_ready || out_valid) begin
            $display("wrong handshake state after reset");
            errors++;
        end
        word_store_load();
        sub_word_stores();
        sub_word_loads();
        out_of_range_access();
        misaligned_access();
        pass_through_stall();
        total = errors + i_lsu_top.i_lsu_checker.fail_cnt;
        $display("errors: %0d (testbench %0d, assertions %0d)",
                 total, errors, i_lsu_top.i_lsu_checker.fail_cnt);
        if (total == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
+incdir+include
hw/lsu_pkg.sv
hw/lsu_ctrl.sv
hw/lsu_rd_engine.sv
hw/lsu_wr_engine.sv
hw/axi_sram.sv
hw/lsu_top.sv
tests/lsu_checker.sv
tests/lsu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the lsu testbench with verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module lsu_tb -f project.f -o lsu_sim > build.log 2>&1 &&
    ./obj_dir/lsu_sim +verilator+error+limit+1000 > sim.log 2>&1 ||
    { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "TB FAILED" sim.log &&
    { echo "simulation reported failure, see sim.log"; exit 1; } ||
    { echo "simulation finished without failure"; exit 0; }
